// ==== source/mem_sys_pkg.sv ====
/*
 * Memory system shared definitions
 * Address map fields, banked memory timing and the
 * cache controller state encoding
 */

package mem_sys_pkg;

   ////////////////////
   // Address map
   ////////////////////

   // Byte address of 16-bit words, bit 0 ignored
   localparam int addr_w = 16;
   localparam int data_w = 16;

   // Bits 15:11
   localparam int tag_w = 5;
   // Bits 10:3, 256 lines
   localparam int index_w = 8;
   // Words per line, also the bank count (bits 2:1)
   localparam int line_words = 4;

   ////////////////////
   // Memory timing
   ////////////////////

   // Read request to valid data
   localparam int mem_rd_latency = 2;
   // Access cycle included
   localparam int bank_busy_cycles = 4;

   ////////////////////
   // Controller states
   ////////////////////

   typedef enum logic [3:0] {
      st_idle,
      // Read path
      st_rd_compare,
      st_rd_writeback,
      st_rd_fill,
      st_rd_return,
      // Write path
      st_wr_compare,
      st_wr_writeback,
      st_wr_fill,
      st_wr_merge
   } ctrl_state_e;

endpackage

// ==== source/cache_port_if.sv ====
/*
 * Cache array port
 * Controller drives mode, address fields and write data,
 * array answers from the addressed line
 */

`timescale 1ns/1ns

interface cache_port_if;

   // Controller side
   logic                                   enable;
   logic                                   comp;
   logic                                   write;
   logic                                   valid_in;
   logic [mem_sys_pkg::tag_w-1:0]          tag_in;
   logic [mem_sys_pkg::index_w-1:0]        index;
   logic [$clog2(mem_sys_pkg::line_words)-1:0] offset;
   logic [mem_sys_pkg::data_w-1:0]         data_in;

   // Array side, combinational
   logic [mem_sys_pkg::data_w-1:0]         data_out;
   logic [mem_sys_pkg::tag_w-1:0]          tag_out;
   logic                                   hit;
   logic                                   dirty;
   logic                                   valid;

   modport ctrl (
      output enable, comp, write, valid_in, tag_in, index, offset, data_in,
      input  data_out, tag_out, hit, dirty, valid
   );

   modport array (
      input  enable, comp, write, valid_in, tag_in, index, offset, data_in,
      output data_out, tag_out, hit, dirty, valid
   );

endinterface

// ==== source/mem_port_if.sv ====
/*
 * Banked memory port
 * Single request per cycle, stall flags a busy bank
 */

`timescale 1ns/1ns

interface mem_port_if;

   // Request from controller
   logic [mem_sys_pkg::addr_w-1:0] addr;
   logic [mem_sys_pkg::data_w-1:0] data_in;
   logic                           wr;
   logic                           rd;

   // Memory response
   logic [mem_sys_pkg::data_w-1:0] data_out;
   logic                           stall;

   modport ctrl (
      output addr, data_in, wr, rd,
      input  data_out, stall
   );

   modport mem (
      input  addr, data_in, wr, rd,
      output data_out, stall
   );

endinterface

// ==== source/cache_array.sv ====
/*
 * Direct-mapped cache storage
 * 256 lines of four words with tag, valid and dirty per line,
 * compare and access modes
 */

`timescale 1ns/1ns

module cache_array (
   input logic         clk,
   input logic         arst_n,
   cache_port_if.array port
);

   import mem_sys_pkg::*;

   localparam int lines = 2 ** index_w;
   localparam int off_w = $clog2(line_words);

   // Word storage, flat over index and offset
   logic [data_w-1:0] data_mem [lines * line_words];
   logic [tag_w-1:0]  tag_mem  [lines];
   logic [lines-1:0]  valid_q;
   logic [lines-1:0]  dirty_q;

   logic [index_w+off_w-1:0] word_addr;
   logic                     tag_match;
   logic                     word_we;
   logic                     tag_we;

   assign word_addr = {port.index, port.offset};

   ////////////////////
   // Line lookup
   ////////////////////

   assign port.data_out = data_mem[word_addr];
   assign port.tag_out  = tag_mem[port.index];
   assign port.valid    = valid_q[port.index];
   assign port.dirty    = dirty_q[port.index];

   assign tag_match = (tag_mem[port.index] == port.tag_in);
   // Hit only meaningful in compare mode
   assign port.hit  = port.enable & port.comp & valid_q[port.index] & tag_match;

   // Compare write needs a hit, access write always lands
   assign word_we = port.enable & port.write & (~port.comp | port.hit);
   assign tag_we  = port.enable & port.write & ~port.comp;

   ////////////////////
   // Storage update
   ////////////////////

   always_ff @(posedge clk) begin
      if (word_we) begin
         data_mem[word_addr] <= port.data_in;
      end
      if (tag_we) begin
         tag_mem[port.index] <= port.tag_in;
      end
   end

   // Line state bits
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (port.enable && port.write) begin
         if (!port.comp) begin
            // Fill word, line now clean
            valid_q[port.index] <= port.valid_in;
            dirty_q[port.index] <= 1'b0;
         end else if (port.hit) begin
            dirty_q[port.index] <= 1'b1;
         end
      end
   end

endmodule

// ==== source/banked_mem.sv ====
/*
 * Four-bank interleaved main memory
 * 32K words, bank picked by address bits 2:1, busy time per
 * bank and a pipelined read path
 */

`timescale 1ns/1ns

module banked_mem (
   input logic       clk,
   input logic       arst_n,
   mem_port_if.mem   port
);

   import mem_sys_pkg::*;

   localparam int off_w = $clog2(line_words);
   localparam int row_w = tag_w + index_w;
   localparam int cnt_w = $clog2(bank_busy_cycles + 1);

   // Banks start cleared
   logic [data_w-1:0] bank_mem [line_words][2 ** row_w] = '{default: '0};

   logic [cnt_w-1:0]  busy_cnt [line_words];
   logic [data_w-1:0] rd_pipe  [mem_rd_latency];

   logic [off_w-1:0]  bank;
   logic [row_w-1:0]  row;
   logic              bank_busy;
   logic              accept;

   // Low word bits pick the bank, the rest the row
   assign bank = port.addr[off_w:1];
   assign row  = port.addr[addr_w-1 -: row_w];

   ////////////////////
   // Bank occupancy
   ////////////////////

   // Access cycle counts as the first busy cycle
   assign bank_busy  = (busy_cnt[bank] > cnt_w'(1));
   assign accept     = (port.rd | port.wr) & ~bank_busy;
   // Request dropped, caller must retry
   assign port.stall = (port.rd | port.wr) & bank_busy;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int b = 0; b < line_words; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < line_words; b++) begin
            if (accept && (bank == off_w'(b))) begin
               busy_cnt[b] <= cnt_w'(bank_busy_cycles);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   ////////////////////
   // Data path
   ////////////////////

   always_ff @(posedge clk) begin
      if (accept && port.wr) begin
         bank_mem[bank][row] <= port.data_in;
      end
   end

   // Several reads in flight, one per stage
   always_ff @(posedge clk) begin
      if (accept && port.rd) begin
         rd_pipe[0] <= bank_mem[bank][row];
      end
      for (int i = 1; i < mem_rd_latency; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign port.data_out = rd_pipe[mem_rd_latency-1];

endmodule

// ==== source/cache_ctrl.sv ====
/*
 * Cache miss controller
 * Captures one CPU request, runs compare, write-back, fill and
 * return or merge, sequenced by a beat counter
 */

`timescale 1ns/1ns

module cache_ctrl (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic [mem_sys_pkg::addr_w-1:0] addr,
   input  logic [mem_sys_pkg::data_w-1:0] data_in,
   input  logic                         rd,
   input  logic                         wr,
   output logic [mem_sys_pkg::data_w-1:0] data_out,
   output logic                         done,
   output logic                         stall,
   output logic                         cache_hit,
   cache_port_if.ctrl                   cache,
   mem_port_if.ctrl                     mem
);

   import mem_sys_pkg::*;

   localparam int off_w  = $clog2(line_words);
   localparam int beat_w = $clog2(line_words + mem_rd_latency);
   // Last write-back beat and last fill beat
   localparam logic [beat_w-1:0] wb_last   = beat_w'(line_words - 1);
   localparam logic [beat_w-1:0] fill_last = beat_w'(line_words + mem_rd_latency - 1);

   ctrl_state_e state_q, state_d;
   logic [beat_w-1:0] beat_q, beat_d;

   // Request capture
   logic [addr_w-1:0] addr_q;
   logic [data_w-1:0] data_q;

   logic [tag_w-1:0]   req_tag;
   logic [index_w-1:0] req_index;
   logic [off_w-1:0]   req_off;
   logic [off_w-1:0]   fill_off;

   assign req_tag   = addr_q[addr_w-1 -: tag_w];
   assign req_index = addr_q[off_w+1 +: index_w];
   assign req_off   = addr_q[off_w:1];
   // Fill write trails its read by the memory latency
   assign fill_off  = off_w'(beat_q - beat_w'(mem_rd_latency));

   ////////////////////
   // Registers
   ////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= st_idle;
         beat_q  <= '0;
      end else begin
         state_q <= state_d;
         beat_q  <= beat_d;
      end
   end

   // Held steady once we leave idle
   always_ff @(posedge clk) begin
      if (state_q == st_idle) begin
         addr_q <= addr;
         data_q <= data_in;
      end
   end

   ////////////////////
   // Next state and outputs
   ////////////////////

   always_comb begin
      state_d   = state_q;
      beat_d    = '0;
      stall     = 1'b1;
      done      = 1'b0;
      cache_hit = 1'b0;
      data_out  = '0;

      // Cache defaults to the requested word, disabled
      cache.enable   = 1'b0;
      cache.comp     = 1'b0;
      cache.write    = 1'b0;
      cache.valid_in = 1'b0;
      cache.tag_in   = req_tag;
      cache.index    = req_index;
      cache.offset   = req_off;
      cache.data_in  = data_q;

      mem.addr    = {req_tag, req_index, beat_q[off_w-1:0], 1'b0};
      mem.data_in = cache.data_out;
      mem.wr      = 1'b0;
      mem.rd      = 1'b0;

      unique case (state_q)
         st_idle: begin
            stall = 1'b0;
            // Read wins a tie
            if (rd) begin
               state_d = st_rd_compare;
            end else if (wr) begin
               state_d = st_wr_compare;
            end
         end

         st_rd_compare, st_wr_compare: begin
            cache.enable = 1'b1;
            cache.comp   = 1'b1;
            cache.write  = (state_q == st_wr_compare);
            data_out     = cache.data_out;
            if (cache.hit) begin
               done      = 1'b1;
               cache_hit = 1'b1;
               state_d   = st_idle;
            end else if (cache.dirty && cache.valid) begin
               state_d = (state_q == st_wr_compare) ? st_wr_writeback : st_rd_writeback;
            end else begin
               state_d = (state_q == st_wr_compare) ? st_wr_fill : st_rd_fill;
            end
         end

         st_rd_writeback, st_wr_writeback: begin
            // Victim word out to its old address
            cache.enable = 1'b1;
            cache.offset = beat_q[off_w-1:0];
            mem.wr       = 1'b1;
            mem.addr     = {cache.tag_out, req_index, beat_q[off_w-1:0], 1'b0};
            beat_d       = mem.stall ? beat_q : beat_q + 1'b1;
            if (!mem.stall && beat_q == wb_last) begin
               beat_d  = '0;
               state_d = (state_q == st_wr_writeback) ? st_wr_fill : st_rd_fill;
            end
         end

         st_rd_fill, st_wr_fill: begin
            // Reads on early beats, cache writes trail them
            mem.rd         = (beat_q < beat_w'(line_words));
            cache.enable   = (beat_q >= beat_w'(mem_rd_latency));
            cache.write    = (beat_q >= beat_w'(mem_rd_latency));
            cache.valid_in = 1'b1;
            cache.offset   = fill_off;
            cache.data_in  = mem.data_out;
            beat_d         = mem.stall ? beat_q : beat_q + 1'b1;
            if (beat_q == fill_last) begin
               beat_d  = '0;
               state_d = (state_q == st_wr_fill) ? st_wr_merge : st_rd_return;
            end
         end

         st_rd_return: begin
            cache.enable = 1'b1;
            data_out     = cache.data_out;
            done         = 1'b1;
            state_d      = st_idle;
         end

         st_wr_merge: begin
            // Compare write marks the line dirty
            cache.enable = 1'b1;
            cache.comp   = 1'b1;
            cache.write  = 1'b1;
            done         = 1'b1;
            state_d      = st_idle;
         end

         default: begin
            state_d = st_idle;
         end
      endcase
   end

endmodule

// ==== source/mem_system.sv ====
/*
 * Cached memory system top
 * Controller, direct-mapped cache and banked memory behind
 * plain CPU strobes
 */

`timescale 1ns/1ns

module mem_system (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic [mem_sys_pkg::addr_w-1:0] addr,
   input  logic [mem_sys_pkg::data_w-1:0] data_in,
   input  logic                           rd,
   input  logic                           wr,
   output logic [mem_sys_pkg::data_w-1:0] data_out,
   output logic                           done,
   output logic                           stall,
   output logic                           cache_hit
);

   // Internal buses
   cache_port_if u_cache_if ();
   mem_port_if   u_mem_if ();

   cache_ctrl u_cache_ctrl (
      .clk       (clk),
      .arst_n    (arst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .cache     (u_cache_if.ctrl),
      .mem       (u_mem_if.ctrl)
   );

   cache_array u_cache_array (
      .clk    (clk),
      .arst_n (arst_n),
      .port   (u_cache_if.array)
   );

   banked_mem u_banked_mem (
      .clk    (clk),
      .arst_n (arst_n),
      .port   (u_mem_if.mem)
   );

endmodule

// ==== bench/mem_system_checker.sv ====
/*
 * Memory system checker
 * Reference model of CPU-visible memory and cache line state,
 * checks data, hit flag, latency, stall and the done pulse
 */

`timescale 1ns/1ns

module mem_system_checker (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic [mem_sys_pkg::addr_w-1:0] addr,
   input  logic [mem_sys_pkg::data_w-1:0] data_in,
   input  logic                           rd,
   input  logic                           wr,
   input  logic [mem_sys_pkg::data_w-1:0] data_out,
   input  logic                           done,
   input  logic                           stall,
   input  logic                           cache_hit,
   output int                             error_count,
   output int                             check_count
);

   import mem_sys_pkg::*;

   // Flat word memory as the CPU sees it
   logic [data_w-1:0]  shadow [2 ** (addr_w - 1)];
   // Per-index line model
   logic [tag_w-1:0]   model_tag [2 ** index_w];
   logic [2**index_w-1:0] model_valid;
   logic [2**index_w-1:0] model_dirty;

   // Request in flight
   logic              busy;
   int                cycles;
   int                exp_latency;
   logic              exp_hit;
   logic              req_is_rd;
   logic [14:0]       req_word;
   logic [data_w-1:0] req_data;

   initial begin
      error_count = 0;
      check_count = 0;
      busy        = 1'b0;
      cycles      = 0;
      model_valid = '0;
      model_dirty = '0;
      for (int i = 0; i < 2 ** (addr_w - 1); i++) begin
         shadow[i] = '0;
      end
      for (int i = 0; i < 2 ** index_w; i++) begin
         model_tag[i] = '0;
      end
   end

   task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
      check_count++;
      if (exp !== act) begin
         error_count++;
         $display("[ERROR] %s expected %0h actual %0h at %0t", test, exp, act, $time);
      end
   endtask

   // Predict outcome, then move the line model forward
   task automatic accept_request();
      logic [4:0] tag;
      logic [7:0] idx;
      logic       line_hit;
      tag       = addr[15:11];
      idx       = addr[10:3];
      line_hit  = model_valid[idx] && (model_tag[idx] == tag);
      req_is_rd = rd;
      req_word  = addr[15:1];
      req_data  = data_in;
      exp_hit   = line_hit;
      // Hit 1, clean miss 8, dirty miss adds 4 write-back beats
      if (line_hit) begin
         exp_latency = 1;
      end else if (model_valid[idx] && model_dirty[idx]) begin
         exp_latency = 12;
      end else begin
         exp_latency = 8;
      end
      model_tag[idx]   = tag;
      model_valid[idx] = 1'b1;
      if (!rd) begin
         model_dirty[idx] = 1'b1;
      end else if (!line_hit) begin
         model_dirty[idx] = 1'b0;
      end
      busy   = 1'b1;
      cycles = 0;
   endtask

   ////////////////////
   // Monitor
   ////////////////////

   // Falling edge, all DUT outputs settled
   always @(negedge clk) begin
      if (!arst_n) begin
         check_value("reset_stall", 0, stall);
         check_value("reset_done", 0, done);
         check_value("reset_hit", 0, cache_hit);
         busy = 1'b0;
      end else if (busy) begin
         cycles++;
         check_value("busy_stall", 1, stall);
         if (done) begin
            check_value("latency", exp_latency, cycles);
            check_value("hit_flag", exp_hit, cache_hit);
            if (req_is_rd) begin
               check_value("read_data", shadow[req_word], data_out);
            end else begin
               shadow[req_word] = req_data;
            end
            busy = 1'b0;
         end else if (cycles == exp_latency + 1) begin
            error_count++;
            $display("done did not arrive within %0d cycles of acceptance at %0t",
                     exp_latency, $time);
         end
      end else begin
         // Idle, no pulses
         check_value("idle_stall", 0, stall);
         check_value("idle_done", 0, done);
         check_value("idle_hit", 0, cache_hit);
         if (rd || wr) begin
            accept_request();
         end
      end
   end

endmodule

// ==== bench/mem_system_tb.sv ====
/*
 * Memory system testbench
 * Random CPU reads and writes over a few conflicting lines,
 * watchdog and closing summary
 */

`timescale 1ns/1ns

module mem_system_tb;

   import mem_sys_pkg::*;

   localparam int num_requests = 400;
   localparam int reset_cycles = 8;
   // Dirty miss, return to idle and an idle gap fit in 14
   localparam int timeout_cycles = reset_cycles + num_requests * 14 + 100;

   logic              clk;
   logic              arst_n;
   logic [addr_w-1:0] addr;
   logic [data_w-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [data_w-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   int                error_count;
   int                check_count;
   int                cycle_count;
   logic [31:0]       rng;

   // Four tags on four indexes force conflicts and evictions
   logic [tag_w-1:0]   tag_pool   [4] = '{5'h00, 5'h0b, 5'h15, 5'h1f};
   logic [index_w-1:0] index_pool [4] = '{8'h00, 8'h3c, 8'h81, 8'hff};

   mem_system u_mem_system (
      .clk       (clk),
      .arst_n    (arst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit)
   );

   mem_system_checker u_checker (
      .clk         (clk),
      .arst_n      (arst_n),
      .addr        (addr),
      .data_in     (data_in),
      .rd          (rd),
      .wr          (wr),
      .data_out    (data_out),
      .done        (done),
      .stall       (stall),
      .cache_hit   (cache_hit),
      .error_count (error_count),
      .check_count (check_count)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   ////////////////////
   // Clock and watchdog
   ////////////////////

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < timeout_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout after %0d cycles, %0d checks, %0d errors",
               cycle_count, check_count, error_count);
      $display("Result: FAILED");
      $finish;
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin
      arst_n  = 1'b0;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      rng     = 32'd79653;
      repeat (reset_cycles) @(posedge clk);
      #2 arst_n = 1'b1;
      for (int n = 0; n < num_requests; n++) begin
         rng = xorshift32(rng);
         // Wait for idle
         while (stall) begin
            @(posedge clk);
            #2;
         end
         // Now and then a cycle with no request
         if (rng[9:7] == 3'd0) begin
            @(posedge clk);
            #2;
         end
         addr    = {tag_pool[rng[2:1]], index_pool[rng[4:3]], rng[6:5], 1'b0};
         data_in = rng[31:16];
         rd      = ~rng[0];
         wr      = rng[0];
         @(posedge clk);
         #2;
         rd = 1'b0;
         wr = 1'b0;
         while (!done) begin
            @(posedge clk);
            #2;
         end
      end
      repeat (2) @(posedge clk);
      $display("Summary: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0 && check_count > 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
source/mem_sys_pkg.sv
source/cache_port_if.sv
source/mem_port_if.sv
source/cache_array.sv
source/banked_mem.sv
source/cache_ctrl.sv
source/mem_system.sv
bench/mem_system_checker.sv
bench/mem_system_tb.sv
